//--- compile.f
+incdir+.
fp_format_pkg.sv
fp_rec_pkg.sv
fp_rec_encode.sv
fp_rec_decode.sv
fp_to_reg.sv
reg_to_fp.sv
fp_regfile.sv
fp_reg_unit.sv
tb_fp_reg_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the fp_reg_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_fp_reg_unit -f compile.f \
  -Mdir obj_dir -o sim_fp_reg_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_fp_reg_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tb_fp_reg_unit.sv
`timescale 1ns/1ps
`include "fp_defs.svh"

module tb_fp_reg_unit;

  localparam int n_rand      = 200;
  localparam int n_dp_extra  = 12;
  localparam int n_sp_extra  = 12;
  localparam int n_box_rand  = 50;
  localparam int n_box_extra = 5;
  localparam int n_mixed     = 300;
  // Each test ends with one idle cycle to drain the read stage.
  localparam int total_ops = 2 + `FP_NREGS + 1 + (n_rand + n_dp_extra) * 2 + 1
                             + (n_rand + n_sp_extra) * 3 + 1
                             + (n_box_rand + n_box_extra) * 3 + 1 + n_mixed + 1;
  localparam int max_cycles = total_ops * 2 + 100;
  localparam logic [63:0] canon_nan = 64'hFFFF_FFFF_7FC0_0000;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  wr_v;
  logic [`FP_REG_AW-1:0] wr_addr;
  logic [`FP_DP_W-1:0]   wr_data;
  logic                  rd_v;
  logic [`FP_REG_AW-1:0] rd_addr;
  logic                  rd_single;
  logic [`FP_DP_W-1:0]   rd_data;
  logic                  rd_data_v;

  // Reference model, raw words as written.
  logic [`FP_DP_W-1:0] model [`FP_NREGS];

  // Expected read result, issue stage and one cycle later.
  logic                iss_v = 1'b0;
  logic [`FP_DP_W-1:0] iss_data = '0;
  logic                held_v = 1'b0;
  logic [`FP_DP_W-1:0] held_data = '0;

  integer seed;
  int     check_cnt = 0;
  int     err_cnt = 0;
  int     test_chk0 = 0;
  int     test_err0 = 0;
  int     cycle_cnt = 0;

  fp_reg_unit u_fp_reg_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_v     (wr_v),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_v     (rd_v),
    .rd_addr  (rd_addr),
    .rd_single(rd_single),
    .rd_data  (rd_data),
    .rd_data_v(rd_data_v)
  );

  always #10 clk = ~clk;

  // --------------------
  // Helpers
  // --------------------

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] t=%0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Boxed singles read back as stored, anything else is the canonical NaN.
  function automatic logic [63:0] expect_read(input logic [63:0] w, input logic single);
    if (!single || w[63:32] == 32'hFFFF_FFFF) begin
      return w;
    end
    return canon_nan;
  endfunction

  function automatic logic [`FP_REG_AW-1:0] rand_addr();
    return `FP_REG_AW'($random(seed));
  endfunction

  function automatic logic rand_bit();
    return 1'($random(seed));
  endfunction

  // Random double, biased toward subnormals and specials, never boxed.
  function automatic logic [63:0] rand_unboxed();
    logic [63:0] w;
    int          cls;
    w   = {$random(seed), $random(seed)};
    cls = $unsigned($random(seed)) % 4;
    if (cls == 1) begin
      w[62:52] = '0;
    end else if (cls == 2) begin
      w[62:52] = '1;
      if (rand_bit()) begin
        w[51:0] = '0;
      end
    end
    if (w[63:32] == 32'hFFFF_FFFF) begin
      w[45] = 1'b0;
    end
    return w;
  endfunction

  function automatic logic [63:0] rand_boxed();
    logic [31:0] s;
    int          cls;
    s   = $random(seed);
    cls = $unsigned($random(seed)) % 4;
    if (cls == 1) begin
      s[30:23] = '0;
    end else if (cls == 2) begin
      s[30:23] = '1;
      if (rand_bit()) begin
        s[22:0] = '0;
      end
    end
    return {32'hFFFF_FFFF, s};
  endfunction

  // Upper half all ones except a single cleared bit.
  function automatic logic [63:0] rand_near_box();
    logic [31:0] hi;
    hi = ~(32'd1 << ($unsigned($random(seed)) % 32));
    return {hi, $random(seed)};
  endfunction

  function automatic logic [63:0] dp_special_word(input int i);
    case (i)
      0:       return 64'h0000_0000_0000_0000;
      1:       return 64'h8000_0000_0000_0000;
      2:       return 64'h0000_0000_0000_0001;
      3:       return 64'h000F_FFFF_FFFF_FFFF;
      4:       return 64'h8000_0000_0000_0001;
      5:       return 64'h7FF0_0000_0000_0000;
      6:       return 64'hFFF0_0000_0000_0000;
      7:       return 64'h7FF8_0000_0000_0000;
      8:       return 64'h7FF0_0000_0000_0001;
      9:       return 64'h7FFA_BCDE_1234_5678;
      10:      return 64'h7FEF_FFFF_FFFF_FFFF;
      default: return 64'h0010_0000_0000_0000;
    endcase
  endfunction

  function automatic logic [63:0] sp_special_word(input int i);
    logic [31:0] s;
    case (i)
      0:       s = 32'h0000_0000;
      1:       s = 32'h8000_0000;
      2:       s = 32'h0000_0001;
      3:       s = 32'h007F_FFFF;
      4:       s = 32'h8000_0001;
      5:       s = 32'h7F80_0000;
      6:       s = 32'hFF80_0000;
      7:       s = 32'h7FC0_0000;
      8:       s = 32'h7F80_0001;
      9:       s = 32'hFFC1_2345;
      10:      s = 32'h7F7F_FFFF;
      default: s = 32'h0080_0000;
    endcase
    return {32'hFFFF_FFFF, s};
  endfunction

  function automatic logic [63:0] near_box_word(input int i);
    case (i)
      0:       return 64'hFFFF_FFFE_3F80_0000;
      1:       return 64'h7FFF_FFFF_3F80_0000;
      2:       return 64'hFFFE_FFFF_7FC0_0000;
      3:       return 64'hFFFF_FF7F_0000_0001;
      default: return 64'h0000_0000_3F80_0000;
    endcase
  endfunction

  // One cycle of traffic. The read sees the model before this cycle's write.
  task automatic step(input logic w, input logic [`FP_REG_AW-1:0] wa,
                      input logic [63:0] wd, input logic r,
                      input logic [`FP_REG_AW-1:0] ra, input logic s);
    @(posedge clk);
    wr_v      <= w;
    wr_addr   <= wa;
    wr_data   <= wd;
    rd_v      <= r;
    rd_addr   <= ra;
    rd_single <= s;
    iss_v    = r;
    iss_data = r ? expect_read(model[ra], s) : 64'd0;
    if (w) begin
      model[wa] = wd;
    end
  endtask

  task automatic idle_cycle();
    step(1'b0, '0, 64'd0, 1'b0, '0, 1'b0);
  endtask

  task automatic write_read(input logic [`FP_REG_AW-1:0] a, input logic [63:0] w,
                            input logic single_too);
    step(1'b1, a, w, 1'b0, '0, 1'b0);
    if (single_too) begin
      step(1'b0, '0, 64'd0, 1'b1, a, 1'b1);
    end
    step(1'b0, '0, 64'd0, 1'b1, a, 1'b0);
  endtask

  task automatic end_test(input string name);
    idle_cycle();
    @(negedge clk);
    #1;
    $display("test %-14s %0d checks, %0d errors", name,
             check_cnt - test_chk0, err_cnt - test_err0);
    test_chk0 = check_cnt;
    test_err0 = err_cnt;
  endtask

  // --------------------
  // Response check
  // --------------------

  // Output of the read issued one cycle earlier is stable at the falling edge.
  always @(negedge clk) begin
    check_val("rd_data_v", 64'(rd_data_v), 64'(held_v));
    if (held_v) begin
      check_val("rd_data", rd_data, held_data);
    end
    held_v    = iss_v;
    held_data = iss_data;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [`FP_REG_AW-1:0] a;
    logic [`FP_REG_AW-1:0] ra;
    logic [63:0]           w;
    seed = 34;
    rst_n     <= 1'b0;
    wr_v      <= 1'b0;
    wr_addr   <= '0;
    wr_data   <= '0;
    rd_v      <= 1'b0;
    rd_addr   <= '0;
    rd_single <= 1'b0;
    for (int i = 0; i < `FP_NREGS; i++) begin
      model[i] = '0;
    end

    repeat (2) idle_cycle();
    rst_n <= 1'b1;
    for (int i = 0; i < `FP_NREGS; i++) begin
      step(1'b0, '0, 64'd0, 1'b1, `FP_REG_AW'(i), 1'b0);
    end
    end_test("reset");

    for (int i = 0; i < n_rand + n_dp_extra; i++) begin
      a = rand_addr();
      w = (i < n_rand) ? rand_unboxed() : dp_special_word(i - n_rand);
      write_read(a, w, 1'b0);
    end
    end_test("dp_round_trip");

    for (int i = 0; i < n_rand + n_sp_extra; i++) begin
      a = rand_addr();
      w = (i < n_rand) ? rand_boxed() : sp_special_word(i - n_rand);
      write_read(a, w, 1'b1);
    end
    end_test("sp_round_trip");

    for (int i = 0; i < n_box_rand + n_box_extra; i++) begin
      a = rand_addr();
      w = (i < n_box_rand) ? rand_near_box() : near_box_word(i - n_box_rand);
      write_read(a, w, 1'b1);
    end
    end_test("box_rule");

    // A quarter of the reads hit the address written on the same edge.
    for (int i = 0; i < n_mixed; i++) begin
      a  = rand_addr();
      w  = rand_bit() ? rand_boxed() : rand_unboxed();
      ra = ($unsigned($random(seed)) % 4 == 0) ? a : rand_addr();
      step(rand_bit(), a, w, 1'b1, ra, rand_bit());
    end
    end_test("back_to_back");

    $display("Total: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- fp_reg_unit.sv
`timescale 1ns/1ps
`include "fp_defs.svh"

module fp_reg_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_v,
  input  logic [`FP_REG_AW-1:0] wr_addr,
  input  logic [`FP_DP_W-1:0]   wr_data,
  input  logic                  rd_v,
  input  logic [`FP_REG_AW-1:0] rd_addr,
  input  logic                  rd_single,
  output logic [`FP_DP_W-1:0]   rd_data,
  output logic                  rd_data_v
);

  import fp_format_pkg::*;
  import fp_rec_pkg::*;

  fp_raw_u wr_raw;
  fp_raw_u rd_raw;
  fp_reg_s wr_word;
  fp_reg_s rd_word;
  logic    rd_single_q;

  // --------------------
  // Write path
  // --------------------
  assign wr_raw = wr_data;

  fp_to_reg u_fp_to_reg (
    .raw     (wr_raw),
    .reg_word(wr_word)
  );

  fp_regfile u_fp_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_v   (wr_v),
    .wr_addr(wr_addr),
    .wr_data(wr_word),
    .rd_v   (rd_v),
    .rd_addr(rd_addr),
    .rd_word(rd_word)
  );

  // --------------------
  // Read path
  // --------------------

  // Format bit follows the entry through the read stage.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data_v   <= 1'b0;
      rd_single_q <= 1'b0;
    end else begin
      rd_data_v <= rd_v;
      if (rd_v) begin
        rd_single_q <= rd_single;
      end
    end
  end

  reg_to_fp u_reg_to_fp (
    .reg_word(rd_word),
    .single  (rd_single_q),
    .raw     (rd_raw)
  );

  assign rd_data = rd_raw;

endmodule

//--- fp_regfile.sv
`timescale 1ns/1ps
`include "fp_defs.svh"

module fp_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_v,
  input  logic [`FP_REG_AW-1:0] wr_addr,
  input  fp_rec_pkg::fp_reg_s   wr_data,
  input  logic                  rd_v,
  input  logic [`FP_REG_AW-1:0] rd_addr,
  output fp_rec_pkg::fp_reg_s   rd_word
);

  import fp_rec_pkg::*;

  // Full-tagged +0.0.
  localparam fp_reg_s reg_zero = '{tag: e_fp_full, rec: '0};

  fp_reg_s regs [`FP_NREGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `FP_NREGS; i++) begin
        regs[i] <= reg_zero;
      end
    end else if (wr_v) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Same-edge write is not seen here, the old entry is returned.
  always_ff @(posedge clk) begin
    if (rd_v) begin
      rd_word <= regs[rd_addr];
    end
  end

endmodule

//--- reg_to_fp.sv
`timescale 1ns/1ps
`include "fp_defs.svh"

module reg_to_fp (
  input  fp_rec_pkg::fp_reg_s    reg_word,
  input  logic                   single,
  output fp_format_pkg::fp_raw_u raw
);

  import fp_rec_pkg::*;

  localparam int rec_dp_ew = `FP_DP_EXP_W + 1;
  localparam int bias_adj  = (1 << (`FP_DP_EXP_W - 1)) - (1 << (`FP_SP_EXP_W - 1));

  fp_rec_dp_s            dp_rec;
  fp_rec_sp_s            sp_rec;
  logic [`FP_DP_EXP_W:0] narrow_exp;
  logic [2:0]            exp_code;
  logic                  special;
  logic [`FP_SP_W-1:0]   sp_raw;
  logic [`FP_DP_W-1:0]   dp_raw;

  assign dp_rec = reg_word.rec;

  // --------------------
  // Narrow back to single.
  // --------------------
  assign exp_code   = dp_rec.exp[`FP_DP_EXP_W -: 3];
  assign special    = (exp_code == 3'b000) || (exp_code[2:1] == 2'b11);
  assign narrow_exp = dp_rec.exp - rec_dp_ew'(bias_adj);

  assign sp_rec = '{sign : dp_rec.sign,
                    exp  : special ? {exp_code, narrow_exp[`FP_SP_EXP_W-3:0]}
                                   : narrow_exp[`FP_SP_EXP_W:0],
                    fract: dp_rec.fract[`FP_DP_SIG_W-2 -: `FP_SP_SIG_W-1]};

  fp_rec_decode #(
    .exp_width(`FP_SP_EXP_W),
    .sig_width(`FP_SP_SIG_W)
  ) u_dec_sp (
    .in (sp_rec),
    .out(sp_raw)
  );

  fp_rec_decode #(
    .exp_width(`FP_DP_EXP_W),
    .sig_width(`FP_DP_SIG_W)
  ) u_dec_dp (
    .in (dp_rec),
    .out(dp_raw)
  );

  // Singles always come back boxed, whatever the read format.
  always_comb begin
    if (reg_word.tag == e_fp_sp) begin
      raw.sp.box = '1;
      {raw.sp.sign, raw.sp.exp, raw.sp.fract} = sp_raw;
    end else if (single) begin
      // Canonical quiet NaN, boxed.
      raw.sp.box   = '1;
      raw.sp.sign  = 1'b0;
      raw.sp.exp   = '1;
      raw.sp.fract = {1'b1, {(`FP_SP_SIG_W - 2){1'b0}}};
    end else begin
      raw.dp = dp_raw;
    end
  end

endmodule

//--- fp_to_reg.sv
`timescale 1ns/1ps
`include "fp_defs.svh"

module fp_to_reg (
  input  fp_format_pkg::fp_raw_u raw,
  output fp_rec_pkg::fp_reg_s    reg_word
);

  import fp_rec_pkg::*;

  localparam int rec_dp_ew = `FP_DP_EXP_W + 1;
  // Difference of the recoded exponent offsets.
  localparam int bias_adj  = (1 << (`FP_DP_EXP_W - 1)) - (1 << (`FP_SP_EXP_W - 1));
  localparam int pad_w     = `FP_DP_SIG_W - `FP_SP_SIG_W;

  fp_rec_sp_s           sp_rec;
  fp_rec_dp_s           dp_rec;
  fp_rec_dp_s           sp_wide;
  logic [`FP_DP_EXP_W:0] adj_exp;
  logic [2:0]           exp_code;
  logic                 special;
  logic                 boxed;

  fp_rec_encode #(
    .exp_width(`FP_SP_EXP_W),
    .sig_width(`FP_SP_SIG_W)
  ) u_enc_sp (
    .in ({raw.sp.sign, raw.sp.exp, raw.sp.fract}),
    .out(sp_rec)
  );

  fp_rec_encode #(
    .exp_width(`FP_DP_EXP_W),
    .sig_width(`FP_DP_SIG_W)
  ) u_enc_dp (
    .in (raw.dp),
    .out(dp_rec)
  );

  // --------------------
  // Widen single to double layout.
  // --------------------
  assign adj_exp  = rec_dp_ew'(sp_rec.exp) + rec_dp_ew'(bias_adj);
  assign exp_code = sp_rec.exp[`FP_SP_EXP_W -: 3];
  // Zero, infinity and NaN keep their code.
  assign special  = (exp_code == 3'b000) || (exp_code[2:1] == 2'b11);

  assign sp_wide = '{sign : sp_rec.sign,
                     exp  : special ? {exp_code, adj_exp[`FP_DP_EXP_W-3:0]} : adj_exp,
                     fract: {sp_rec.fract, {pad_w{1'b0}}}};

  assign boxed = &raw.sp.box;

  assign reg_word = '{tag: boxed ? e_fp_sp : e_fp_full,
                      rec: boxed ? sp_wide : dp_rec};

endmodule

//--- fp_rec_decode.sv
`timescale 1ns/1ps

module fp_rec_decode #(
  parameter int exp_width = 8,
  parameter int sig_width = 24
) (
  input  logic [exp_width+sig_width:0]   in,
  output logic [exp_width+sig_width-1:0] out
);

  localparam int frac_w = sig_width - 1;
  localparam int rec_ew = exp_width + 1;
  localparam logic [rec_ew-1:0] norm_ofs = rec_ew'((1 << (exp_width - 1)) + 1);
  // Smallest recoded exponent of a normal number.
  localparam logic [rec_ew-1:0] min_norm = norm_ofs + 1'b1;

  logic                 sign;
  logic [rec_ew-1:0]    rec_exp;
  logic [frac_w-1:0]    rec_fract;
  logic [2:0]           exp_code;
  logic                 is_zero;
  logic                 is_special;
  logic                 is_sub;
  logic [rec_ew-1:0]    sub_shift;
  logic [sig_width-1:0] sub_sig;
  logic [exp_width-1:0] exp_out;
  logic [frac_w-1:0]    fract_out;

  assign {sign, rec_exp, rec_fract} = in;

  assign exp_code   = rec_exp[rec_ew-1 -: 3];
  assign is_zero    = (exp_code == 3'b000);
  assign is_special = (exp_code[2:1] == 2'b11);
  assign is_sub     = (rec_exp < min_norm);

  // Put the hidden one back and shift it into the fraction.
  assign sub_shift = min_norm - rec_exp;
  assign sub_sig   = {1'b1, rec_fract} >> sub_shift;

  always_comb begin
    if (is_zero) begin
      exp_out   = '0;
      fract_out = '0;
    end else if (is_special) begin
      // Fraction carries the NaN payload through.
      exp_out   = '1;
      fract_out = rec_fract;
    end else if (is_sub) begin
      exp_out   = '0;
      fract_out = sub_sig[frac_w-1:0];
    end else begin
      exp_out   = exp_width'(rec_exp - norm_ofs);
      fract_out = rec_fract;
    end
  end

  assign out = {sign, exp_out, fract_out};

endmodule

//--- fp_rec_encode.sv
`timescale 1ns/1ps

module fp_rec_encode #(
  parameter int exp_width = 8,
  parameter int sig_width = 24
) (
  input  logic [exp_width+sig_width-1:0] in,
  output logic [exp_width+sig_width:0]   out
);

  localparam int frac_w = sig_width - 1;
  localparam int nd_w   = $clog2(sig_width);
  localparam int rec_ew = exp_width + 1;
  // Offset from IEEE biased exponent to recoded exponent.
  localparam logic [rec_ew-1:0] norm_ofs = rec_ew'((1 << (exp_width - 1)) + 1);

  logic                 sign;
  logic [exp_width-1:0] exp_in;
  logic [frac_w-1:0]    fract_in;
  logic                 exp_zero;
  logic                 exp_ones;
  logic                 fract_zero;
  logic [nd_w-1:0]      norm_dist;
  logic [frac_w-1:0]    sub_fract;
  logic [rec_ew-1:0]    rec_exp;
  logic [frac_w-1:0]    rec_fract;

  // Count of zeros above the first set fraction bit.
  function automatic logic [nd_w-1:0] lead_zeros(input logic [frac_w-1:0] f);
    logic [nd_w-1:0] n;
    logic            done;
    n    = '0;
    done = 1'b0;
    for (int i = frac_w - 1; i >= 0; i--) begin
      if (!done) begin
        if (f[i]) begin
          done = 1'b1;
        end else begin
          n = n + 1'b1;
        end
      end
    end
    return n;
  endfunction

  assign {sign, exp_in, fract_in} = in;
  assign exp_zero   = (exp_in == '0);
  assign exp_ones   = &exp_in;
  assign fract_zero = (fract_in == '0);

  // Subnormals are shifted up until the leading one drops off the top.
  assign norm_dist = lead_zeros(fract_in);
  assign sub_fract = (fract_in << norm_dist) << 1;

  always_comb begin
    if (exp_ones) begin
      // Infinity is 110, NaN is 111.
      rec_exp = {2'b11, !fract_zero, {(exp_width - 2){1'b0}}};
    end else if (exp_zero && fract_zero) begin
      rec_exp = '0;
    end else if (exp_zero) begin
      rec_exp = norm_ofs - rec_ew'(norm_dist);
    end else begin
      rec_exp = rec_ew'(exp_in) + norm_ofs;
    end
    rec_fract = exp_zero ? sub_fract : fract_in;
  end

  assign out = {sign, rec_exp, rec_fract};

endmodule

//--- fp_rec_pkg.sv
`include "fp_defs.svh"

package fp_rec_pkg;

  // --------------------
  // Recoded formats
  // --------------------

  // Recoded single, exponent is one bit wider than IEEE.
  typedef struct packed {
    logic                   sign;
    logic [`FP_SP_EXP_W:0]  exp;
    logic [`FP_SP_SIG_W-2:0] fract;
  } fp_rec_sp_s;

  // Recoded double, the layout of every register entry.
  typedef struct packed {
    logic                                   sign;
    logic [`FP_DP_EXP_W:0]                  exp;
    logic [`FP_REC_DP_W-`FP_DP_EXP_W-3:0]   fract;
  } fp_rec_dp_s;

  // Tag says how the entry was written.
  typedef enum logic {
    e_fp_full = 1'b0,
    e_fp_sp   = 1'b1
  } fp_tag_e;

  typedef struct packed {
    fp_tag_e    tag;
    fp_rec_dp_s rec;
  } fp_reg_s;

endpackage

//--- fp_format_pkg.sv
`include "fp_defs.svh"

package fp_format_pkg;

  // --------------------
  // Raw IEEE views
  // --------------------

  // Double precision word as stored in memory.
  typedef struct packed {
    logic                     sign;
    logic [`FP_DP_EXP_W-1:0]  exp;
    logic [`FP_DP_SIG_W-2:0]  fract;
  } fp_raw_dp_s;

  // Single precision in the low half, box field above it.
  // A legal boxed single has the box field all ones.
  typedef struct packed {
    logic [`FP_DP_W-`FP_SP_W-1:0] box;
    logic                         sign;
    logic [`FP_SP_EXP_W-1:0]      exp;
    logic [`FP_SP_SIG_W-2:0]      fract;
  } fp_raw_sp_s;

  // One 64-bit load or store word, read either way.
  typedef union packed {
    fp_raw_dp_s dp;
    fp_raw_sp_s sp;
  } fp_raw_u;

endpackage

//--- fp_defs.svh
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

// --------------------
// Single precision.
// --------------------
`define FP_SP_EXP_W 8
// Significand width counts the hidden bit.
`define FP_SP_SIG_W 24
`define FP_SP_W     32

// --------------------
// Double precision.
// --------------------
`define FP_DP_EXP_W 11
`define FP_DP_SIG_W 53
`define FP_DP_W     64

// Recoded double, one extra exponent bit.
`define FP_REC_DP_W 65

// --------------------
// Register file.
// --------------------
`define FP_NREGS    32
`define FP_REG_AW   5

`endif
